/* src/sbox_pkg.sv */
package sbox_pkg;

  localparam int NUM_PORTS = 2;

  typedef logic [1:0] gf4_t;      // a0 + a1*w, with w^2 = w + 1.
  typedef logic [5:0] gf_word_t;  // Digits d2:d1:d0, d0 in bits 1:0.
  typedef logic       port_id_t;

  typedef struct packed {
    port_id_t port;
    gf_word_t data;
  } sbox_req_t;

  typedef struct packed {
    port_id_t port;
    gf_word_t data;    // Echoed input.
    gf_word_t result;
  } sbox_resp_t;

  function automatic gf4_t gf4_mul(gf4_t a, gf4_t b);
    logic hi;
    begin
      hi = a[1] & b[1];  // w^2 term folds back into both bits.
      gf4_mul[0] = (a[0] & b[0]) ^ hi;
      gf4_mul[1] = (a[0] & b[1]) ^ (a[1] & b[0]) ^ hi;
    end
  endfunction

  function automatic gf4_t gf4_sq(gf4_t a);
    begin
      gf4_sq[0] = a[0] ^ a[1];
      gf4_sq[1] = a[1];
    end
  endfunction

endpackage

/* src/gf_tower_power.sv */
`timescale 1ns/1ps
module gf_tower_power
  import sbox_pkg::*;
(
  input  gf_word_t a,
  output gf_word_t b
);

  localparam gf4_t W = 2'b10;  // The element w, also t^3.

  // Frobenius map. t^4 = w*t, so d2^2 moves to the t digit.
  function automatic gf_word_t tw_sq(gf_word_t x);
    begin
      tw_sq = {gf4_sq(x[3:2]), gf4_mul(W, gf4_sq(x[5:4])), gf4_sq(x[1:0])};
    end
  endfunction

  // Schoolbook product, reduced with t^3 = w.
  function automatic gf_word_t tw_mul(gf_word_t x, gf_word_t y);
    gf4_t x0, x1, x2;
    gf4_t y0, y1, y2;
    gf4_t c0, c1, c2, c3, c4;
    begin
      x0 = x[1:0];
      x1 = x[3:2];
      x2 = x[5:4];
      y0 = y[1:0];
      y1 = y[3:2];
      y2 = y[5:4];
      c0 = gf4_mul(x0, y0);
      c1 = gf4_mul(x0, y1) ^ gf4_mul(x1, y0);
      c2 = gf4_mul(x0, y2) ^ gf4_mul(x1, y1) ^ gf4_mul(x2, y0);
      c3 = gf4_mul(x1, y2) ^ gf4_mul(x2, y1);
      c4 = gf4_mul(x2, y2);
      tw_mul[1:0] = c0 ^ gf4_mul(W, c3);
      tw_mul[3:2] = c1 ^ gf4_mul(W, c4);  // t^4 = w*t.
      tw_mul[5:4] = c2;
    end
  endfunction

  gf_word_t a2;
  gf_word_t a4;
  gf_word_t a8;
  gf_word_t a16;
  gf_word_t a32;
  gf_word_t a20;

  // 52 = 32 + 16 + 4.
  assign a2  = tw_sq(a);
  assign a4  = tw_sq(a2);
  assign a8  = tw_sq(a4);
  assign a16 = tw_sq(a8);
  assign a32 = tw_sq(a16);

  assign a20 = tw_mul(a4, a16);
  assign b   = tw_mul(a20, a32);

endmodule

/* src/sbox_pipe.sv */
`timescale 1ns/1ps
module sbox_pipe
  import sbox_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       issue_valid,
  input  sbox_req_t  issue,
  output logic       done_valid,
  output sbox_resp_t done
);

  gf_word_t  pow;
  logic      s1_valid;
  sbox_req_t s1_req;
  gf_word_t  s1_pow;
  logic      fold;

  gf_tower_power u_power (
    .a (issue.data),
    .b (pow)
  );

  // Stage 1. Power map result.
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= issue_valid;
    end
    s1_req <= issue;
    s1_pow <= pow;
  end

  assign fold = s1_req.data[2] ^ s1_req.data[4];  // Affine term from input bits.

  // Stage 2. Affine step and response.
  always_ff @(posedge clk) begin
    if (rst) begin
      done_valid <= 1'b0;
    end else begin
      done_valid <= s1_valid;
    end
    done.port   <= s1_req.port;
    done.data   <= s1_req.data;
    done.result <= s1_pow ^ {6{fold}};
  end

endmodule

/* src/req_port.sv */
`timescale 1ns/1ps
module req_port
  import sbox_pkg::*;
#(
  parameter int       REQ_DEPTH = 4,
  parameter port_id_t PORT      = 1'b0
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      req_valid,
  input  gf_word_t  req_data,
  input  logic      pop,
  output logic      head_valid,
  output sbox_req_t head,
  output logic      req_credit
);

  localparam int AW = $clog2(REQ_DEPTH);

  gf_word_t      mem [REQ_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          push;
  logic          take;

  assign push = req_valid && (count != REQ_DEPTH[AW:0]);  // Drop on overflow.
  assign take = pop && head_valid;

  assign head_valid = (count != '0);
  assign head.port  = PORT;
  assign head.data  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= req_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      req_credit <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (take) rd_ptr <= rd_ptr + 1'b1;
      case ({push, take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      req_credit <= take;  // One credit back per entry issued.
    end
  end

endmodule

/* src/pipe_arbiter.sv */
`timescale 1ns/1ps
module pipe_arbiter
  import sbox_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [NUM_PORTS-1:0] head_valid,
  input  sbox_req_t            head [NUM_PORTS],
  input  logic [NUM_PORTS-1:0] has_space,
  output logic [NUM_PORTS-1:0] grant,
  output logic                 issue_valid,
  output sbox_req_t            issue
);

  logic [NUM_PORTS-1:0] eligible;
  port_id_t             pick;
  port_id_t             last_grant;

  assign eligible    = head_valid & has_space;
  assign issue_valid = |eligible;

  // On a tie the port not served last wins.
  assign pick  = eligible[1] && (!eligible[0] || last_grant == 1'b0);
  assign issue = head[pick];

  always_comb begin
    grant = '0;
    if (issue_valid) begin
      grant[pick] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      last_grant <= 1'b1;  // Port 0 takes the first tie.
    end else if (issue_valid) begin
      last_grant <= pick;
    end
  end

endmodule

/* src/resp_port.sv */
`timescale 1ns/1ps
module resp_port
  import sbox_pkg::*;
#(
  parameter int RESP_DEPTH = 4
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       reserve,
  input  logic       wr_valid,
  input  sbox_resp_t wr_data,
  input  logic       resp_credit,
  output logic       has_space,
  output logic       resp_valid,
  output sbox_resp_t resp_data
);

  localparam int AW       = $clog2(RESP_DEPTH);
  localparam int CREDIT_W = 8;

  sbox_resp_t          mem [RESP_DEPTH];
  logic [AW-1:0]       wr_ptr;
  logic [AW-1:0]       rd_ptr;
  logic [AW:0]         count;     // Stored entries.
  logic [AW:0]         rsv;       // Stored plus in flight.
  logic [CREDIT_W-1:0] credits;

  assign resp_valid = (count != '0) && (credits != '0);
  assign resp_data  = mem[rd_ptr];
  assign has_space  = (rsv < RESP_DEPTH[AW:0]);

  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      rsv     <= '0;
      credits <= '0;
    end else begin
      if (wr_valid) wr_ptr <= wr_ptr + 1'b1;
      if (resp_valid) rd_ptr <= rd_ptr + 1'b1;
      count   <= count + wr_valid - resp_valid;
      rsv     <= rsv + reserve - resp_valid;        // Slot freed on send.
      credits <= credits + resp_credit - resp_valid;
    end
  end

endmodule

/* src/sbox_top.sv */
`timescale 1ns/1ps
module sbox_top
  import sbox_pkg::*;
#(
  parameter int REQ_DEPTH  = 4,
  parameter int RESP_DEPTH = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [NUM_PORTS-1:0] req_valid,
  input  gf_word_t             req_data [NUM_PORTS],
  output logic [NUM_PORTS-1:0] req_credit,
  input  logic [NUM_PORTS-1:0] resp_credit,
  output logic [NUM_PORTS-1:0] resp_valid,
  output sbox_resp_t           resp_data [NUM_PORTS]
);

  logic [NUM_PORTS-1:0] head_valid;
  sbox_req_t            head [NUM_PORTS];
  logic [NUM_PORTS-1:0] has_space;
  logic [NUM_PORTS-1:0] grant;
  logic [NUM_PORTS-1:0] wr_valid;
  logic                 issue_valid;
  sbox_req_t            issue;
  logic                 done_valid;
  sbox_resp_t           done;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    req_port #(
      .REQ_DEPTH (REQ_DEPTH),
      .PORT      (port_id_t'(p))
    ) u_req (
      .clk        (clk),
      .rst        (rst),
      .req_valid  (req_valid[p]),
      .req_data   (req_data[p]),
      .pop        (grant[p]),
      .head_valid (head_valid[p]),
      .head       (head[p]),
      .req_credit (req_credit[p])
    );

    assign wr_valid[p] = done_valid && (done.port == port_id_t'(p));  // Route by tag.

    resp_port #(
      .RESP_DEPTH (RESP_DEPTH)
    ) u_resp (
      .clk         (clk),
      .rst         (rst),
      .reserve     (grant[p]),
      .wr_valid    (wr_valid[p]),
      .wr_data     (done),
      .resp_credit (resp_credit[p]),
      .has_space   (has_space[p]),
      .resp_valid  (resp_valid[p]),
      .resp_data   (resp_data[p])
    );
  end

  pipe_arbiter u_arb (
    .clk         (clk),
    .rst         (rst),
    .head_valid  (head_valid),
    .head        (head),
    .has_space   (has_space),
    .grant       (grant),
    .issue_valid (issue_valid),
    .issue       (issue)
  );

  sbox_pipe u_pipe (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue       (issue),
    .done_valid  (done_valid),
    .done        (done)
  );

endmodule

/* tests/tb_sbox_top.sv */
`timescale 1ns/1ps
module tb_sbox_top
  import sbox_pkg::*;
();

  localparam int REQ_DEPTH  = 4;
  localparam int RESP_DEPTH = 4;
  localparam int NUM_ROWS   = 128;
  localparam int LIMIT      = 40 * NUM_ROWS + 200;

  typedef struct packed {
    port_id_t   port;
    gf_word_t   word;
    logic [1:0] cred;  // Consumer credit enable per port.
  } row_t;

  logic                 clk;
  logic                 rst;
  logic [NUM_PORTS-1:0] req_valid;
  gf_word_t             req_data [NUM_PORTS];
  logic [NUM_PORTS-1:0] req_credit;
  logic [NUM_PORTS-1:0] resp_credit;
  logic [NUM_PORTS-1:0] resp_valid;
  sbox_resp_t           resp_data [NUM_PORTS];

  row_t       rows [NUM_ROWS];
  gf_word_t   exp_q [NUM_PORTS][$];
  int         pcred [NUM_PORTS];  // Producer credits held.
  int         ccred [NUM_PORTS];  // Consumer grants not yet used.
  int         sent [NUM_PORTS];
  int         credit_cnt [NUM_PORTS];
  logic [1:0] cred_en;
  logic       quiet;
  int         cycles;
  int         errors;
  int         err_mark;
  int         tests;
  int         failed_tests;

  sbox_top #(
    .REQ_DEPTH  (REQ_DEPTH),
    .RESP_DEPTH (RESP_DEPTH)
  ) UUT (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req_data    (req_data),
    .req_credit  (req_credit),
    .resp_credit (resp_credit),
    .resp_valid  (resp_valid),
    .resp_data   (resp_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // (a0 + a1 w)(b0 + b1 w) with w^2 = w + 1.
  function automatic logic [1:0] ref_mul4(logic [1:0] a, logic [1:0] b);
    ref_mul4[0] = (a[0] & b[0]) ^ (a[1] & b[1]);
    ref_mul4[1] = (a[0] & b[1]) ^ (a[1] & b[0]) ^ (a[1] & b[1]);
  endfunction

  function automatic gf_word_t ref_mul64(gf_word_t x, gf_word_t y);
    logic [1:0] c [5];
    for (int k = 0; k < 5; k++) c[k] = 2'b00;
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        c[i+j] = c[i+j] ^ ref_mul4(x[2*i +: 2], y[2*j +: 2]);
      end
    end
    for (int k = 4; k >= 3; k--) begin
      c[k-3] = c[k-3] ^ ref_mul4(2'b10, c[k]);  // t^3 = w.
    end
    return {c[2], c[1], c[0]};
  endfunction

  function automatic gf_word_t sbox_ref(gf_word_t x);
    gf_word_t p;
    p = 6'b000001;
    for (int n = 0; n < 52; n++) p = ref_mul64(p, x);
    return p ^ {6{x[2] ^ x[4]}};
  endfunction

  task automatic report_error(string msg);
    $display("ERROR: %s", msg);
    errors++;
  endtask

  task automatic check_resp(int p, sbox_resp_t got, sbox_resp_t want);
    if (got !== want) begin
      $display("FAIL resp_data[%0d] got %h expected %h", p, got, want);
      errors++;
    end
  endtask

  task automatic check_credit(int p);
    if (credit_cnt[p] != sent[p]) begin
      $display("FAIL req_credit[%0d] pulses got %h expected %h", p, credit_cnt[p], sent[p]);
      errors++;
    end
  endtask

  // Grants only cover results still owed, so none are left over.
  task automatic step();
    @(negedge clk);
    req_valid = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      resp_credit[p] = cred_en[p] && (ccred[p] < RESP_DEPTH) &&
                       (ccred[p] < exp_q[p].size());
      if (resp_credit[p]) ccred[p]++;
    end
  endtask

  task automatic apply_row(row_t r);
    step();
    cred_en = r.cred;
    while (pcred[r.port] == 0) begin
      step();
    end
    req_valid[r.port] = 1'b1;
    req_data[r.port]  = r.word;
    pcred[r.port]--;
    sent[r.port]++;
    exp_q[r.port].push_back(r.word);
  endtask

  task automatic finish_rows();
    cred_en = 2'b11;
    while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
      step();
    end
    repeat (4) step();
    check_credit(0);
    check_credit(1);
  endtask

  task automatic run_rows(int lo, int hi);
    for (int i = lo; i < hi; i++) apply_row(rows[i]);
    finish_rows();
  endtask

  task automatic do_reset();
    rst     = 1'b1;
    cred_en = 2'b00;
    step();
    step();
    rst = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      exp_q[p].delete();
      pcred[p]      = REQ_DEPTH;
      ccred[p]      = 0;
      sent[p]       = 0;
      credit_cnt[p] = 0;
    end
  endtask

  task automatic report_test(string name);
    tests++;
    if (errors == err_mark) begin
      $display("Test %0d %s: ok", tests, name);
    end else begin
      failed_tests++;
      $display("Test %0d %s: %0d errors", tests, name, errors - err_mark);
    end
    err_mark = errors;
    for (int p = 0; p < NUM_PORTS; p++) begin
      sent[p]       = 0;
      credit_cnt[p] = 0;
    end
  endtask

  always @(posedge clk) begin : monitor
    gf_word_t   x;
    sbox_resp_t want;
    if (!rst) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (quiet && (req_credit[p] || resp_valid[p]))
          report_error($sformatf("port %0d active after reset with no traffic", p));
        if (req_credit[p]) begin
          credit_cnt[p]++;
          pcred[p]++;
          if (pcred[p] > REQ_DEPTH)
            report_error($sformatf("port %0d returned more credits than requests", p));
        end
        if (resp_valid[p]) begin
          if (ccred[p] == 0) report_error($sformatf("port %0d sent without credit", p));
          else ccred[p]--;
          if (exp_q[p].size() == 0) begin
            report_error($sformatf("port %0d sent an unexpected response", p));
          end else begin
            x           = exp_q[p].pop_front();
            want.port   = port_id_t'(p);
            want.data   = x;
            want.result = sbox_ref(x);
            check_resp(p, resp_data[p], want);
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("Timeout after %0d cycles, responses still missing", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin : main
    rst         = 1'b1;
    req_valid   = '0;
    req_data    = '{default: '0};
    resp_credit = '0;
    cred_en     = 2'b00;
    quiet       = 1'b0;
    cycles      = 0;
    errors      = 0;
    err_mark    = 0;
    tests       = 0;
    failed_tests = 0;
    void'($urandom(32'h2972986c));
    for (int i = 0; i < 64; i++) rows[i] = '{port: 1'b0, word: gf_word_t'(i), cred: 2'b11};
    for (int i = 64; i < NUM_ROWS; i++) begin
      rows[i].port = port_id_t'(i % 2);
      rows[i].word = gf_word_t'($urandom);
      rows[i].cred = (i < 96) ? 2'b11 : (i < 112) ? 2'b01 : (i < 120) ? 2'b00 : 2'b11;
    end
    @(posedge clk);
    do_reset();
    run_rows(0, 64);
    report_test("all 64 words on port 0");
    run_rows(64, 96);
    report_test("both ports, order and credit return");
    for (int i = 96; i < 112; i++) apply_row(rows[i]);
    while (exp_q[0].size() != 0) step();
    repeat (4) step();
    if (exp_q[1].size() != 8) report_error("port 1 delivered results with no consumer credit");
    finish_rows();
    report_test("port 1 back-pressure");
    for (int i = 112; i < 120; i++) apply_row(rows[i]);
    do_reset();
    quiet = 1'b1;
    repeat (8) step();
    quiet = 1'b0;
    run_rows(120, NUM_ROWS);
    report_test("reset during traffic");
    $display("Tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* src.f */
src/sbox_pkg.sv
src/gf_tower_power.sv
src/sbox_pipe.sv
src/req_port.sv
src/pipe_arbiter.sv
src/resp_port.sv
src/sbox_top.sv
tests/tb_sbox_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_sbox_top -f src.f \
  --Mdir obj_dir -o Vtb_sbox_top > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_sbox_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

grep -q "ALL TESTS PASSED" sim.log
exit $?
